//--- filelist.f
source/memory_pkg.sv
source/dtlb_fill_if.sv
source/dtlb_replacement_block.sv
source/dtlb_entry_array.sv
source/dtlb_miss_tracker.sv
source/dtlb.sv
test/tb_dtlb.sv

//--- source/dtlb.sv
// Eight-entry data TLB with one outstanding miss and no page walk, ASID or superpage support
`default_nettype none
`timescale 1ns/1ps

module dtlb (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  // Lookup from the load/store unit
  input  logic             lookup_valid_i,
  input  memory_pkg::vpn_t lookup_vpn_i,
  input  logic             lookup_store_i,
  // Lookup response, one cycle later
  output logic             resp_valid_o,
  output logic             resp_hit_o,
  output memory_pkg::ppn_t resp_ppn_o,
  output logic             resp_fault_o,
  // L2 side
  output logic             l2_req_o,
  output memory_pkg::vpn_t l2_req_vpn_o,
  input  logic             l2_refill_valid_i,
  input  memory_pkg::vpn_t l2_refill_vpn_i,
  input  memory_pkg::ppn_t l2_refill_ppn_i,
  input  logic             l2_refill_writable_i,
  output logic             miss_pending_o
);
  import memory_pkg::*;

  // Array to replacement block
  logic [D_TLB_ENTRIES-1:0] valid_vec;
  logic [D_TLB_ENTRIES-1:0] hit_vec;
  logic [D_TLB_ENTRIES-1:0] replace_vec;

  // Captured lookup VPN for the miss tracker
  vpn_t resp_vpn;

  dtlb_fill_if fill_bus ();

  dtlb_entry_array i_entry_array (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .lookup_valid_i (lookup_valid_i),
    .lookup_vpn_i   (lookup_vpn_i),
    .lookup_store_i (lookup_store_i),
    .fill           (fill_bus.array),
    .replace_vec_i  (replace_vec),
    .valid_vec_o    (valid_vec),
    .hit_vec_o      (hit_vec),
    .resp_valid_o   (resp_valid_o),
    .resp_hit_o     (resp_hit_o),
    .resp_vpn_o     (resp_vpn),
    .resp_ppn_o     (resp_ppn_o),
    .resp_fault_o   (resp_fault_o)
  );

  // Fill strobe doubles as the replacement access
  dtlb_replacement_block i_replacement_block (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .tlb_valid_vec_i         (valid_vec),
    .valid_tlb_read_i        (lookup_valid_i),
    .valid_tlb_replacement_i (fill_bus.fill_valid),
    .hit_vec_i               (hit_vec),
    .replace_vec_o           (replace_vec)
  );

  dtlb_miss_tracker i_miss_tracker (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .resp_valid_i         (resp_valid_o),
    .resp_hit_i           (resp_hit_o),
    .resp_vpn_i           (resp_vpn),
    .l2_req_o             (l2_req_o),
    .l2_req_vpn_o         (l2_req_vpn_o),
    .l2_refill_valid_i    (l2_refill_valid_i),
    .l2_refill_vpn_i      (l2_refill_vpn_i),
    .l2_refill_ppn_i      (l2_refill_ppn_i),
    .l2_refill_writable_i (l2_refill_writable_i),
    .miss_pending_o       (miss_pending_o),
    .fill                 (fill_bus.tracker)
  );

endmodule

`default_nettype wire

//--- source/dtlb_entry_array.sv
// Fully associative storage with a registered lookup response and no duplicate-VPN detection
`default_nettype none
`timescale 1ns/1ps

module dtlb_entry_array (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  logic                                 lookup_valid_i,
  input  memory_pkg::vpn_t                     lookup_vpn_i,
  input  logic                                 lookup_store_i,
  dtlb_fill_if.array                           fill,
  input  logic [memory_pkg::D_TLB_ENTRIES-1:0] replace_vec_i,
  output logic [memory_pkg::D_TLB_ENTRIES-1:0] valid_vec_o,
  output logic [memory_pkg::D_TLB_ENTRIES-1:0] hit_vec_o,
  output logic                                 resp_valid_o,
  output logic                                 resp_hit_o,
  output memory_pkg::vpn_t                     resp_vpn_o,
  output memory_pkg::ppn_t                     resp_ppn_o,
  output logic                                 resp_fault_o
);
  import memory_pkg::*;

  // Translation entries
  dtlb_entry_t entry_q [D_TLB_ENTRIES];

  // Combinational lookup result
  logic lookup_hit;
  ppn_t hit_ppn;
  logic hit_writable;

  // Response registers
  logic resp_valid_q;
  logic resp_hit_q;
  logic resp_fault_q;
  vpn_t resp_vpn_q;
  ppn_t resp_ppn_q;

  // Valid bits and per-entry VPN compare
  always_comb begin
    for (int k = 0; k < D_TLB_ENTRIES; k++) begin
      valid_vec_o[k] = entry_q[k].valid;
      hit_vec_o[k]   = entry_q[k].valid && (entry_q[k].vpn == lookup_vpn_i);
    end
  end

  // AND-OR mux over the one-hot hit vector
  always_comb begin
    hit_ppn      = '0;
    hit_writable = 1'b0;
    for (int k = 0; k < D_TLB_ENTRIES; k++) begin
      if (hit_vec_o[k]) begin
        hit_ppn      = hit_ppn | entry_q[k].ppn;
        hit_writable = hit_writable | entry_q[k].writable;
      end
    end
  end

  assign lookup_hit = |hit_vec_o;

  // Entry update
  // Flush drops every translation, a fill writes the victim picked by the PLRU
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < D_TLB_ENTRIES; k++) begin
        entry_q[k] <= '0;
      end
    end else if (flush_i) begin
      for (int k = 0; k < D_TLB_ENTRIES; k++) begin
        entry_q[k].valid <= 1'b0;
      end
    end else if (fill.fill_valid) begin
      for (int k = 0; k < D_TLB_ENTRIES; k++) begin
        if (replace_vec_i[k]) begin
          entry_q[k] <= '{valid:    1'b1,
                          vpn:      fill.fill_vpn,
                          ppn:      fill.fill_ppn,
                          writable: fill.fill_writable};
        end
      end
    end
  end

  // Response flags, hit and fault only mean something with valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      resp_hit_q   <= 1'b0;
      resp_fault_q <= 1'b0;
    end else begin
      resp_valid_q <= lookup_valid_i;
      resp_hit_q   <= lookup_valid_i && lookup_hit;
      // Store to a page without write permission
      resp_fault_q <= lookup_valid_i && lookup_hit && lookup_store_i && !hit_writable;
    end
  end

  // Captured VPN and translated PPN
  always_ff @(posedge clk_i) begin
    if (lookup_valid_i) begin
      resp_vpn_q <= lookup_vpn_i;
      resp_ppn_q <= hit_ppn;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_hit_o   = resp_hit_q;
  assign resp_fault_o = resp_fault_q;
  assign resp_vpn_o   = resp_vpn_q;
  assign resp_ppn_o   = resp_ppn_q;

endmodule

`default_nettype wire

//--- source/dtlb_fill_if.sv
// Refill path carries no handshake and fill_valid is a single-cycle strobe
`default_nettype none
`timescale 1ns/1ps

interface dtlb_fill_if;
  import memory_pkg::*;

  // Write strobe for the selected victim entry
  logic fill_valid;
  // Translation to be written
  vpn_t fill_vpn;
  ppn_t fill_ppn;
  logic fill_writable;

  // Miss tracker side drives the refill
  modport tracker (output fill_valid, fill_vpn, fill_ppn, fill_writable);

  // Entry array side consumes it
  modport array (input fill_valid, fill_vpn, fill_ppn, fill_writable);

endinterface

`default_nettype wire

//--- source/dtlb_miss_tracker.sv
// Single outstanding miss only and the L2 side must accept every request without back-pressure
`default_nettype none
`timescale 1ns/1ps

module dtlb_miss_tracker (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  // Registered lookup response
  input  logic             resp_valid_i,
  input  logic             resp_hit_i,
  input  memory_pkg::vpn_t resp_vpn_i,
  // Request towards L2
  output logic             l2_req_o,
  output memory_pkg::vpn_t l2_req_vpn_o,
  // Refill from L2
  input  logic             l2_refill_valid_i,
  input  memory_pkg::vpn_t l2_refill_vpn_i,
  input  memory_pkg::ppn_t l2_refill_ppn_i,
  input  logic             l2_refill_writable_i,
  output logic             miss_pending_o,
  dtlb_fill_if.tracker     fill
);
  import memory_pkg::*;

  // Outstanding miss state
  logic pending_q;
  vpn_t pending_vpn_q;
  logic req_q;

  logic new_miss;
  logic refill_match;

  // Miss with nothing in flight starts a request
  // Misses while one is pending are dropped
  assign new_miss = resp_valid_i && !resp_hit_i && !pending_q;

  // Only the refill for the pending page is written
  // A flush in the same cycle cancels it
  assign refill_match = l2_refill_valid_i && pending_q &&
                        (l2_refill_vpn_i == pending_vpn_q) && !flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      req_q     <= 1'b0;
    end else begin
      // Request is a one-cycle pulse
      req_q <= new_miss && !flush_i;
      if (flush_i) begin
        pending_q <= 1'b0;
      end else if (new_miss) begin
        pending_q <= 1'b1;
      end else if (refill_match) begin
        pending_q <= 1'b0;
      end
    end
  end

  // Page being fetched, also used as request address
  always_ff @(posedge clk_i) begin
    if (new_miss) begin
      pending_vpn_q <= resp_vpn_i;
    end
  end

  assign l2_req_o       = req_q;
  assign l2_req_vpn_o   = pending_vpn_q;
  assign miss_pending_o = pending_q;

  // Forward refill to the entry array in the same cycle
  assign fill.fill_valid    = refill_match;
  assign fill.fill_vpn      = l2_refill_vpn_i;
  assign fill.fill_ppn      = l2_refill_ppn_i;
  assign fill.fill_writable = l2_refill_writable_i;

endmodule

`default_nettype wire

//--- source/dtlb_replacement_block.sv
// Tree PLRU for exactly eight entries with invalid-first filling and a one-hot victim output
`default_nettype none
`timescale 1ns/1ps

module dtlb_replacement_block (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [memory_pkg::D_TLB_ENTRIES-1:0] tlb_valid_vec_i,
  input  logic                                 valid_tlb_read_i,
  input  logic                                 valid_tlb_replacement_i,
  input  logic [memory_pkg::D_TLB_ENTRIES-1:0] hit_vec_i,
  output logic [memory_pkg::D_TLB_ENTRIES-1:0] replace_vec_o
);
  import memory_pkg::*;

  // Tree node state, 0 points the victim to the lower half
  logic       root_q;
  logic [1:0] mid_q;
  logic [3:0] leaf_q;

  // Node enables and next values
  logic       root_en;
  logic       root_d;
  logic [1:0] mid_en;
  logic [1:0] mid_d;
  logic [3:0] leaf_en;
  logic [3:0] leaf_d;

  // Lookup that hits in this cycle
  logic read_hit;

  // Entry touched in this cycle, one-hot or zero
  logic [D_TLB_ENTRIES-1:0] access_vec;

  // Victim candidates
  logic [D_TLB_IDX_W-1:0] plru_idx;
  logic [D_TLB_IDX_W-1:0] invalid_idx;
  logic [D_TLB_IDX_W-1:0] victim_idx;
  logic                   all_valid;

  // A lookup that misses is no access
  assign read_hit = valid_tlb_read_i && |hit_vec_i;

  // Hit or fill selects the accessed entry
  // A hit and a fill together leave the tree unchanged
  always_comb begin
    access_vec = '0;
    if (read_hit && !valid_tlb_replacement_i) begin
      access_vec = hit_vec_i;
    end else if (valid_tlb_replacement_i && !read_hit) begin
      access_vec = replace_vec_o;
    end
  end

  // Leaf to root update
  // Each node on the path is set to point away from the accessed entry
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      leaf_en[k] = access_vec[2*k] | access_vec[2*k+1];
      // Lower entry accessed so point to the upper one
      leaf_d[k]  = access_vec[2*k];
    end
    for (int k = 0; k < 2; k++) begin
      mid_en[k] = leaf_en[2*k] | leaf_en[2*k+1];
      mid_d[k]  = leaf_en[2*k];
    end
    root_en = mid_en[0] | mid_en[1];
    root_d  = mid_en[0];
  end

  // Seven enabled node flops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      root_q <= 1'b0;
      mid_q  <= '0;
      leaf_q <= '0;
    end else begin
      if (root_en) begin
        root_q <= root_d;
      end
      for (int k = 0; k < 2; k++) begin
        if (mid_en[k]) begin
          mid_q[k] <= mid_d[k];
        end
      end
      for (int k = 0; k < 4; k++) begin
        if (leaf_en[k]) begin
          leaf_q[k] <= leaf_d[k];
        end
      end
    end
  end

  // Walk the tree from root to leaf for the PLRU index
  assign plru_idx[2] = root_q;
  assign plru_idx[1] = mid_q[plru_idx[2]];
  assign plru_idx[0] = leaf_q[plru_idx[2:1]];

  // Lowest invalid entry, scanning down so index 0 wins
  always_comb begin
    invalid_idx = '0;
    for (int k = D_TLB_ENTRIES - 1; k >= 0; k--) begin
      if (!tlb_valid_vec_i[k]) begin
        invalid_idx = D_TLB_IDX_W'(k);
      end
    end
  end

  // PLRU only once every entry holds a translation
  assign all_valid  = &tlb_valid_vec_i;
  assign victim_idx = all_valid ? plru_idx : invalid_idx;

  // One-hot victim for the entry array
  always_comb begin
    for (int k = 0; k < D_TLB_ENTRIES; k++) begin
      replace_vec_o[k] = (victim_idx == D_TLB_IDX_W'(k));
    end
  end

endmodule

`default_nettype wire

//--- source/memory_pkg.sv
// Geometry is fixed at eight entries because the PLRU tree has exactly three levels
`default_nettype none

package memory_pkg;

  // Number of d-TLB entries
  // The tree PLRU in the replacement block only supports this value
  localparam int unsigned D_TLB_ENTRIES = 8;

  // Entry index width, matches the three tree levels
  localparam int unsigned D_TLB_IDX_W = 3;

  // Page number widths for 4 KiB pages on a 32-bit address space
  localparam int unsigned VPN_W = 20;
  localparam int unsigned PPN_W = 20;

  // Virtual page number
  typedef logic [VPN_W-1:0] vpn_t;

  // Physical page number
  typedef logic [PPN_W-1:0] ppn_t;

  // One translation entry
  // Only store permission is tracked, reads are always allowed
  typedef struct packed {
    logic valid;
    vpn_t vpn;
    ppn_t ppn;
    logic writable;
  } dtlb_entry_t;

endpackage

`default_nettype wire

//--- test/tb_dtlb.sv
// Lookups and refills never share a cycle, and the model keeps its tree across flushes like the DUT
`default_nettype none
`timescale 1ns/1ps

module tb_dtlb;
  import memory_pkg::*;

  localparam int CLK_PERIOD  = 40;
  // Lookups and refills, each bounded by ten cycles
  localparam int PLANNED_OPS = 90;
  localparam int TAB_SIZE    = 12;

  logic clk_i;
  logic rst_ni;
  logic flush_i;
  logic lookup_valid_i;
  vpn_t lookup_vpn_i;
  logic lookup_store_i;
  logic resp_valid_o;
  logic resp_hit_o;
  ppn_t resp_ppn_o;
  logic resp_fault_o;
  logic l2_req_o;
  vpn_t l2_req_vpn_o;
  logic l2_refill_valid_i;
  vpn_t l2_refill_vpn_i;
  ppn_t l2_refill_ppn_i;
  logic l2_refill_writable_i;
  logic miss_pending_o;

  // Page table seen by the L2 responder
  vpn_t vpn_list [TAB_SIZE];
  ppn_t ppn_list [TAB_SIZE];
  logic wr_list  [TAB_SIZE];

  // Reference model of entries, tree and miss state
  logic       m_valid [D_TLB_ENTRIES];
  vpn_t       m_vpn   [D_TLB_ENTRIES];
  ppn_t       m_ppn   [D_TLB_ENTRIES];
  logic       m_wr    [D_TLB_ENTRIES];
  logic       m_root;
  logic [1:0] m_mid;
  logic [3:0] m_leaf;
  logic       m_pending;
  vpn_t       m_pending_vpn;

  // Outputs expected after the current edge
  logic exp_resp_valid;
  logic exp_hit;
  logic exp_fault;
  ppn_t exp_ppn;
  vpn_t exp_resp_vpn;
  logic exp_req;
  vpn_t exp_req_vpn;

  int err_count;
  int check_count;

  dtlb i_dtlb (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .lookup_valid_i       (lookup_valid_i),
    .lookup_vpn_i         (lookup_vpn_i),
    .lookup_store_i       (lookup_store_i),
    .resp_valid_o         (resp_valid_o),
    .resp_hit_o           (resp_hit_o),
    .resp_ppn_o           (resp_ppn_o),
    .resp_fault_o         (resp_fault_o),
    .l2_req_o             (l2_req_o),
    .l2_req_vpn_o         (l2_req_vpn_o),
    .l2_refill_valid_i    (l2_refill_valid_i),
    .l2_refill_vpn_i      (l2_refill_vpn_i),
    .l2_refill_ppn_i      (l2_refill_ppn_i),
    .l2_refill_writable_i (l2_refill_writable_i),
    .miss_pending_o       (miss_pending_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                 input logic [31:0] gotv);
    $display("ERR %0t %s expected %0h got %0h", $time, sig, expv, gotv);
    err_count++;
  endtask

  // Lowest invalid entry first, else walk the tree from the root
  function automatic int pick_victim();
    int r;
    int m;
    int l;
    for (int k = 0; k < D_TLB_ENTRIES; k++) begin
      if (!m_valid[k]) begin
        return k;
      end
    end
    r = m_root;
    m = m_mid[r];
    l = m_leaf[2*r+m];
    return 4*r + 2*m + l;
  endfunction

  // Point every node on the path away from the accessed entry
  task automatic touch_entry(input int idx);
    m_root        = (idx < 4);
    m_mid[idx/4]  = ((idx / 2) % 2 == 0);
    m_leaf[idx/2] = (idx % 2 == 0);
  endtask

  // Model and checks share one block so expectations line up with each edge
  always @(posedge clk_i) begin : model_check
    int   hit_idx;
    int   vic;
    logic hit;
    logic new_miss;
    logic match;
    if (!rst_ni) begin
      for (int k = 0; k < D_TLB_ENTRIES; k++) begin
        m_valid[k] = 1'b0;
      end
      m_root = 1'b0;
      m_mid = '0;
      m_leaf = '0;
      m_pending = 1'b0;
      exp_resp_valid = 1'b0;
      exp_req = 1'b0;
    end else begin
      check_count++;
      // Outputs of the cycle that just ended
      assert (resp_valid_o == exp_resp_valid)
        else report_mismatch("resp_valid_o", exp_resp_valid, resp_valid_o);
      if (exp_resp_valid) begin
        assert (resp_hit_o == exp_hit) else report_mismatch("resp_hit_o", exp_hit, resp_hit_o);
        assert (resp_fault_o == exp_fault)
          else report_mismatch("resp_fault_o", exp_fault, resp_fault_o);
        if (exp_hit) begin
          assert (resp_ppn_o == exp_ppn) else report_mismatch("resp_ppn_o", exp_ppn, resp_ppn_o);
        end
      end
      assert (l2_req_o == exp_req) else report_mismatch("l2_req_o", exp_req, l2_req_o);
      if (exp_req) begin
        assert (l2_req_vpn_o == exp_req_vpn)
          else report_mismatch("l2_req_vpn_o", exp_req_vpn, l2_req_vpn_o);
      end
      assert (miss_pending_o == m_pending)
        else report_mismatch("miss_pending_o", m_pending, miss_pending_o);

      // Next state from the inputs sampled at this edge
      hit_idx = -1;
      for (int k = 0; k < D_TLB_ENTRIES; k++) begin
        if (m_valid[k] && m_vpn[k] == lookup_vpn_i) begin
          hit_idx = k;
        end
      end
      hit      = lookup_valid_i && (hit_idx >= 0);
      vic      = pick_victim();
      new_miss = exp_resp_valid && !exp_hit && !m_pending;
      match    = l2_refill_valid_i && m_pending && (l2_refill_vpn_i == m_pending_vpn) && !flush_i;

      exp_req     = new_miss && !flush_i;
      exp_req_vpn = exp_resp_vpn;
      if (flush_i) begin
        m_pending = 1'b0;
      end else if (new_miss) begin
        m_pending     = 1'b1;
        m_pending_vpn = exp_resp_vpn;
      end else if (match) begin
        m_pending = 1'b0;
      end

      // Hit and fill together leave the tree alone
      if (hit && !match) begin
        touch_entry(hit_idx);
      end else if (match && !hit) begin
        touch_entry(vic);
      end

      exp_resp_valid = lookup_valid_i;
      exp_hit        = hit;
      exp_ppn        = hit ? m_ppn[hit_idx] : '0;
      exp_fault      = hit && lookup_store_i && !m_wr[hit_idx];
      exp_resp_vpn   = lookup_vpn_i;

      if (flush_i) begin
        for (int k = 0; k < D_TLB_ENTRIES; k++) begin
          m_valid[k] = 1'b0;
        end
      end else if (match) begin
        m_valid[vic] = 1'b1;
        m_vpn[vic]   = l2_refill_vpn_i;
        m_ppn[vic]   = l2_refill_ppn_i;
        m_wr[vic]    = l2_refill_writable_i;
      end
    end
  end

  task automatic drive_lookup(input int idx, input logic store);
    @(posedge clk_i);
    lookup_valid_i <= 1'b1;
    lookup_vpn_i   <= vpn_list[idx];
    lookup_store_i <= store;
    @(posedge clk_i);
    lookup_valid_i <= 1'b0;
  endtask

  task automatic wait_request();
    while (!l2_req_o) begin
      @(posedge clk_i);
    end
  endtask

  // One refill strobe, matching or not
  task automatic drive_refill(input int idx);
    @(posedge clk_i);
    l2_refill_valid_i    <= 1'b1;
    l2_refill_vpn_i      <= vpn_list[idx];
    l2_refill_ppn_i      <= ppn_list[idx];
    l2_refill_writable_i <= wr_list[idx];
    @(posedge clk_i);
    l2_refill_valid_i <= 1'b0;
  endtask

  // Refill after a random 1 to 5 cycle latency, then wait for the miss to close
  task automatic answer_refill(input int idx);
    repeat ($urandom_range(5, 1)) @(posedge clk_i);
    drive_refill(idx);
    while (miss_pending_o) begin
      @(posedge clk_i);
    end
  endtask

  // L2 responder for a request that is still to come
  task automatic serve_miss(input int idx);
    wait_request();
    answer_refill(idx);
  endtask

  // Full lookup, refilled from the table when it misses
  task automatic lookup(input int idx, input logic store);
    drive_lookup(idx, store);
    @(posedge clk_i);
    if (!resp_hit_o && !miss_pending_o) begin
      serve_miss(idx);
    end
  endtask

  task automatic flush_tlb();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  initial begin : stimulus
    void'($urandom(32'h13f));
    err_count            = 0;
    check_count          = 0;
    rst_ni               = 1'b0;
    flush_i              = 1'b0;
    lookup_valid_i       = 1'b0;
    lookup_vpn_i         = '0;
    lookup_store_i       = 1'b0;
    l2_refill_valid_i    = 1'b0;
    l2_refill_vpn_i      = '0;
    l2_refill_ppn_i      = '0;
    l2_refill_writable_i = 1'b0;
    // Upper VPN bits hold the table index so all pages differ
    for (int k = 0; k < TAB_SIZE; k++) begin
      vpn_list[k] = (vpn_t'(k) << 16) | vpn_t'($urandom_range(16'hffff, 0));
      ppn_list[k] = ppn_t'($urandom);
      wr_list[k]  = $urandom_range(1, 0);
    end
    wr_list[0] = 1'b0;
    wr_list[1] = 1'b1;
    repeat (3) @(posedge clk_i);
    // Response, request and pending flags are cleared while reset is held
    assert (!resp_valid_o && !l2_req_o && !miss_pending_o) else begin
      $display("Outputs not low while reset is asserted at %0t", $time);
      err_count++;
    end
    rst_ni <= 1'b1;

    // Cold misses, refills into invalid entries, then hits
    for (int k = 0; k < D_TLB_ENTRIES; k++) begin
      lookup(k, 1'b0);
      lookup(k, 1'b0);
    end
    for (int k = 0; k < D_TLB_ENTRIES; k++) begin
      lookup(k, 1'b0);
    end

    // Random hits shape the tree before a ninth page evicts
    repeat (12) lookup($urandom_range(7, 0), 1'b0);
    lookup(8, 1'b0);
    for (int k = 0; k < 9; k++) begin
      lookup(k, 1'b0);
    end

    // Load then store to each page for the fault rule
    for (int k = 0; k < 9; k++) begin
      lookup(k, 1'b0);
      lookup(k, 1'b1);
    end

    // Pending miss blocks new requests while hits still answer
    drive_lookup(9, 1'b0);
    wait_request();
    drive_lookup(10, 1'b0);
    drive_lookup(8, 1'b1);
    drive_refill(10);
    answer_refill(9);
    drive_refill(11);
    lookup(9, 1'b0);

    // Flush drops the pending miss and all entries
    drive_lookup(10, 1'b0);
    wait_request();
    flush_tlb();
    drive_refill(10);
    for (int k = 0; k < 4; k++) begin
      lookup(k, 1'b0);
    end

    repeat (3) @(posedge clk_i);
    $display("Checked cycles: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    #(PLANNED_OPS * 10 * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
